//--- alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire mipsPkg::aluOp_e op_i,
    input  wire mipsPkg::word_t  a_i,
    input  wire mipsPkg::word_t  b_i,
    input  wire mipsPkg::shamt_t shamt_i,
    output mipsPkg::word_t       result_o,
    output logic                 equal_o
);
    import mipsPkg::*;

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i; // wraps, no overflow trap
            ALU_SUB:  result_o = a_i - b_i;
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_NOR:  result_o = ~(a_i | b_i);
            ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: result_o = {31'b0, a_i < b_i};
            ALU_SLL:  result_o = b_i << shamt_i; // shifts act on rt
            ALU_SRL:  result_o = b_i >> shamt_i;
            ALU_SRA:  result_o = word_t'($signed(b_i) >>> shamt_i);
            ALU_LUI:  result_o = {b_i[15:0], 16'b0};
            default:  result_o = a_i + b_i;
        endcase
    end

    // beq and bne compare rs with rt
    assign equal_o = (a_i == b_i);

endmodule

`default_nettype wire

//--- hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  wire mipsPkg::regAddr_t rsE_i,
    input  wire mipsPkg::regAddr_t rtE_i,
    input  wire mipsPkg::regAddr_t rsD_i,
    input  wire mipsPkg::regAddr_t rtD_i,
    input  wire mipsPkg::regAddr_t destM_i,
    input  wire mipsPkg::regAddr_t destW_i,
    input  wire                    regWriteM_i,
    input  wire                    regWriteW_i,
    input  wire                    memReadE_i,
    input  wire mipsPkg::regAddr_t destE_i,
    input  wire                    redirectE_i,
    output mipsPkg::fwdSel_e       fwdA_o,
    output mipsPkg::fwdSel_e       fwdB_o,
    output logic                   stall_o,
    output logic                   flushF_o
);
    import mipsPkg::*;

    // memory stage is younger, so it wins over write-back
    function automatic fwdSel_e pickSource(input regAddr_t src);
        fwdSel_e sel;
        sel = FWD_RF;
        if (src != '0) begin
            if (regWriteM_i && destM_i == src) begin
                sel = FWD_MEM;
            end else if (regWriteW_i && destW_i == src) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwdA_o = pickSource(rsE_i);
        fwdB_o = pickSource(rtE_i);
    end

    // load data only exists in memory, one bubble needed
    assign stall_o = memReadE_i && destE_i != '0 && (destE_i == rsD_i || destE_i == rtD_i);

    assign flushF_o = redirectE_i; // delay slot in decode survives

endmodule

`default_nettype wire

//--- instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
    input  wire mipsPkg::word_t instr_i,
    output mipsPkg::ctrl_t      ctrl_o,
    output mipsPkg::word_t      imm_o
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr_t   rt;
    regAddr_t   rd;
    logic       zeroExt;
    ctrl_t      ctrl;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];
    assign rt     = instr_i[20:16];
    assign rd     = instr_i[15:11];

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = ALU_ADD;
        ctrl.dest  = rt; // i-type default
        zeroExt    = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                ctrl.dest     = rd;
                ctrl.regWrite = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_XOR:  ctrl.aluOp = ALU_XOR;
                    FN_NOR:  ctrl.aluOp = ALU_NOR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    FN_SLTU: ctrl.aluOp = ALU_SLTU;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        ctrl.aluOp        = (funct == FN_SLL) ? ALU_SLL :
                                            (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                        ctrl.shiftByShamt = 1'b1;
                    end
                    FN_JR: begin
                        ctrl.isJr     = 1'b1;
                        ctrl.regWrite = 1'b0;
                    end
                    default: ctrl.regWrite = 1'b0; // unknown funct runs as nop
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                zeroExt       = opcode inside {OP_ANDI, OP_ORI, OP_XORI};
                case (opcode)
                    OP_SLTI: ctrl.aluOp = ALU_SLT;
                    OP_ANDI: ctrl.aluOp = ALU_AND;
                    OP_ORI:  ctrl.aluOp = ALU_OR;
                    OP_XORI: ctrl.aluOp = ALU_XOR;
                    OP_LUI:  ctrl.aluOp = ALU_LUI;
                    default: ctrl.aluOp = ALU_ADD;
                endcase
            end
            OP_LW: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
            end
            OP_SW: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.aluOp    = ALU_SUB;
                ctrl.isBranch = 1'b1;
                ctrl.branchNe = (opcode == OP_BNE);
            end
            OP_J, OP_JAL: begin
                ctrl.isJump   = 1'b1;
                ctrl.link     = (opcode == OP_JAL);
                ctrl.regWrite = (opcode == OP_JAL);
                ctrl.dest     = RA_REG;
            end
            default: ; // anything else is a nop
        endcase
        if (ctrl.dest == '0) begin
            ctrl.regWrite = 1'b0; // $0 is never written
        end
    end

    assign ctrl_o = ctrl;

    // j and jal carry the 26-bit index in the immediate
    assign imm_o = (opcode == OP_J || opcode == OP_JAL) ? {6'b0, instr_i[25:0]} :
                   zeroExt ? {16'b0, instr_i[15:0]} :
                   {{16{instr_i[15]}}, instr_i[15:0]};

endmodule

`default_nettype wire

//--- mipsCore.sv
`timescale 1ns/10ps
`default_nettype none

module mipsCore (
    input  wire                 clk,
    input  wire                 reset_i,
    output mipsPkg::word_t      instrAddr_o,
    output logic                instrEn_o,
    input  wire mipsPkg::word_t instr_i,
    output logic                memEn_o,
    output logic                memWe_o,
    output mipsPkg::word_t      memAddr_o,
    output mipsPkg::word_t      memWdata_o,
    input  wire mipsPkg::word_t memRdata_i,
    output mipsPkg::wbTrace_t   trace_o
);
    import mipsPkg::*;

    word_t   pcF;
    logic    stall;
    logic    flushF;
    logic    redirectE;
    word_t   redirectTarget;

    word_t   pcD;
    word_t   instrD;
    ctrl_t   ctrlD;
    word_t   immD;
    word_t   rsValD;
    word_t   rtValD;
    deReg_t  deReg;

    fwdSel_e fwdA;
    fwdSel_e fwdB;
    word_t   srcA;
    word_t   rtFwd;
    word_t   srcB;
    shamt_t  shamtE;
    word_t   aluResult;
    logic    equalE;
    word_t   pcPlus4E;
    word_t   branchTarget;
    word_t   jumpTarget;

    emReg_t  emReg;
    word_t   resultM;
    mwReg_t  mwReg;

    function automatic word_t fwdMux(input fwdSel_e sel, input word_t rfVal,
                                     input word_t memVal, input word_t wbVal);
        word_t val;
        case (sel)
            FWD_MEM: val = memVal;
            FWD_WB:  val = wbVal;
            default: val = rfVal;
        endcase
        return val;
    endfunction

    // fetch
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pcF <= RESET_PC;
        end else if (redirectE) begin
            pcF <= redirectTarget;
        end else if (!stall) begin
            pcF <= pcF + 32'd4;
        end
    end

    assign instrAddr_o = pcF;
    assign instrEn_o   = ~reset_i;

    always_ff @(posedge clk) begin
        if (reset_i || flushF) begin
            instrD <= '0; // all-zero word is a nop
        end else if (!stall) begin
            instrD <= instr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcD <= pcF;
        end
    end

    // decode
    instrDecoder uDecoder (
        .instr_i (instrD),
        .ctrl_o  (ctrlD),
        .imm_o   (immD)
    );

    regFile uRegFile (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (mwReg.regWrite),
        .waddr_i  (mwReg.dest),
        .wdata_i  (mwReg.result),
        .raddrA_i (instrD[25:21]),
        .raddrB_i (instrD[20:16]),
        .rdataA_o (rsValD),
        .rdataB_o (rtValD)
    );

    always_ff @(posedge clk) begin
        deReg <= '{ctrl: ctrlD, pc: pcD, rs: instrD[25:21], rt: instrD[20:16],
                   rsVal: rsValD, rtVal: rtValD, imm: immD, shamt: instrD[10:6]};
        if (reset_i || stall) begin
            deReg.ctrl <= '0; // bubble into execute
        end
    end

    // execute
    assign srcA   = fwdMux(fwdA, deReg.rsVal, resultM, mwReg.result);
    assign rtFwd  = fwdMux(fwdB, deReg.rtVal, resultM, mwReg.result);
    assign srcB   = deReg.ctrl.useImm ? deReg.imm : rtFwd;
    assign shamtE = deReg.ctrl.shiftByShamt ? deReg.shamt : srcA[4:0];

    alu uAlu (
        .op_i     (deReg.ctrl.aluOp),
        .a_i      (srcA),
        .b_i      (srcB),
        .shamt_i  (shamtE),
        .result_o (aluResult),
        .equal_o  (equalE)
    );

    assign pcPlus4E     = deReg.pc + 32'd4;
    assign branchTarget = pcPlus4E + {deReg.imm[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4E[31:28], deReg.imm[25:0], 2'b00};
    assign redirectE    = (deReg.ctrl.isBranch && (equalE ^ deReg.ctrl.branchNe))
                        || deReg.ctrl.isJump || deReg.ctrl.isJr;
    assign redirectTarget = deReg.ctrl.isJr   ? srcA :       // forwarded rs
                            deReg.ctrl.isJump ? jumpTarget : branchTarget;

    hazardUnit uHazard (
        .rsE_i       (deReg.rs),
        .rtE_i       (deReg.rt),
        .rsD_i       (instrD[25:21]),
        .rtD_i       (instrD[20:16]),
        .destM_i     (emReg.ctrl.dest),
        .destW_i     (mwReg.dest),
        .regWriteM_i (emReg.ctrl.regWrite),
        .regWriteW_i (mwReg.regWrite),
        .memReadE_i  (deReg.ctrl.memRead),
        .destE_i     (deReg.ctrl.dest),
        .redirectE_i (redirectE),
        .fwdA_o      (fwdA),
        .fwdB_o      (fwdB),
        .stall_o     (stall),
        .flushF_o    (flushF)
    );

    always_ff @(posedge clk) begin
        emReg <= '{ctrl: deReg.ctrl, pc: deReg.pc, aluResult: aluResult, storeData: rtFwd};
        if (reset_i) begin
            emReg.ctrl <= '0;
        end
    end

    // memory
    assign memEn_o    = emReg.ctrl.memRead | emReg.ctrl.memWrite;
    assign memWe_o    = emReg.ctrl.memWrite;
    assign memAddr_o  = emReg.aluResult;
    assign memWdata_o = emReg.storeData;

    assign resultM = emReg.ctrl.memRead ? memRdata_i :
                     emReg.ctrl.link    ? emReg.pc + 32'd8 : emReg.aluResult;

    always_ff @(posedge clk) begin
        mwReg <= '{regWrite: emReg.ctrl.regWrite, pc: emReg.pc,
                   dest: emReg.ctrl.dest, result: resultM};
        if (reset_i) begin
            mwReg.regWrite <= 1'b0;
        end
    end

    // write-back trace
    assign trace_o = '{pc: mwReg.pc, wen: mwReg.regWrite, wnum: mwReg.dest,
                       wdata: mwReg.result};

endmodule

`default_nettype wire

//--- mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef logic [31:0] word_t;    // data or address word
    typedef logic [4:0]  regAddr_t; // register number
    typedef logic [4:0]  shamt_t;   // shift amount

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } aluOp_e;

    typedef enum logic [1:0] {
        FWD_RF,  // value read in decode
        FWD_MEM, // result of the memory stage
        FWD_WB   // result held in write-back
    } fwdSel_e;

    // control fields; dest travels with them so the $0 check stays in the decoder
    typedef struct packed {
        aluOp_e   aluOp;
        regAddr_t dest;
        logic     useImm;       // immediate as operand b
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     isBranch;
        logic     branchNe;     // bne instead of beq
        logic     isJump;       // j and jal
        logic     isJr;
        logic     link;         // pc+8 to the destination
        logic     shiftByShamt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc;
        regAddr_t rs;
        regAddr_t rt;
        word_t    rsVal;
        word_t    rtVal;
        word_t    imm;
        shamt_t   shamt;
    } deReg_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t pc;
        word_t aluResult;
        word_t storeData;
    } emReg_t;

    typedef struct packed {
        logic     regWrite;
        word_t    pc;
        regAddr_t dest;
        word_t    result;
    } mwReg_t;

    typedef struct packed {
        word_t    pc;
        logic     wen;
        regAddr_t wnum;
        word_t    wdata;
    } wbTrace_t;

    localparam word_t    RESET_PC = 32'hbfc0_0000;
    localparam regAddr_t RA_REG   = 5'd31;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

`default_nettype wire

//--- regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    we_i,
    input  wire mipsPkg::regAddr_t waddr_i,
    input  wire mipsPkg::word_t    wdata_i,
    input  wire mipsPkg::regAddr_t raddrA_i,
    input  wire mipsPkg::regAddr_t raddrB_i,
    output mipsPkg::word_t         rdataA_o,
    output mipsPkg::word_t         rdataB_o
);
    import mipsPkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write shows through to decode
    function automatic word_t readPort(input regAddr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (we_i && addr == waddr_i) begin
            val = wdata_i;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rdataA_o = readPort(raddrA_i);
        rdataB_o = readPort(raddrB_i);
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/10ps \
        --top-module tbMipsCore -f sim.f \
    && ./obj_dir/VtbMipsCore | tee /dev/stderr | grep -q "^Result: PASSED$" \
    && echo "simulation ok" \
    || { echo "simulation failed" >&2; exit 1; }

//--- sim.f
+incdir+.
mipsPkg.sv
instrDecoder.sv
regFile.sv
alu.sv
hazardUnit.sv
mipsCore.sv
tbMipsCore.sv

//--- tbIsaModel.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// register-register format with operands in assembly order
function automatic word_t encR(logic [5:0] fn, int rd, int rs, int rt, int sh);
    return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
endfunction

// immediate format where a branch compares rt with rs
function automatic word_t encI(logic [5:0] op, int rt, int rs, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

function automatic word_t addrOf(int idx);
    return RESET_PC + word_t'(idx) * 32'd4;
endfunction

function automatic word_t encJ(logic [5:0] op, int idx);
    word_t target;
    target = addrOf(idx);
    return {op, target[27:2]};
endfunction

task automatic clearProgram();
    for (int i = 0; i < 256; i++) begin
        imem[i] = '0; // nop
    end
    progLen = 0;
endtask

task automatic emitInstr(word_t w);
    imem[progLen] = w;
    progLen++;
endtask

task automatic endProgram();
    emitInstr(encJ(OP_J, progLen)); // parks the core
    emitInstr(32'h0);               // its delay slot
endtask

// in-order ISA model with one delay slot that fills expQ and memQ
// and returns the executed count
function automatic int runModel();
    word_t    regs [32];
    word_t    mem [256];
    word_t    pc;
    word_t    npc;
    word_t    nnpc;
    word_t    ins;
    word_t    a;
    word_t    b;
    word_t    sImm;
    word_t    zImm;
    word_t    val;
    word_t    addr;
    logic [5:0] op;
    logic [5:0] fn;
    regAddr_t dest;
    logic     wr;
    logic     stop;
    int       steps;
    wbTrace_t entry;
    memAccess_t acc;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        mem[i] = fillWord(i);
    end
    expQ.delete();
    memQ.delete();
    pc = RESET_PC;
    npc = RESET_PC + 32'd4;
    steps = 0;
    stop = 1'b0;
    while (!stop) begin
        ins = imem[pc[9:2]];
        op = ins[31:26];
        fn = ins[5:0];
        a = regs[ins[25:21]];
        b = regs[ins[20:16]];
        sImm = {{16{ins[15]}}, ins[15:0]};
        zImm = {16'h0, ins[15:0]};
        addr = a + sImm;
        if ((op == OP_J && {npc[31:28], ins[25:0], 2'b00} == pc) || steps >= 1000) begin
            stop = 1'b1; // reached the self jump
        end else begin
            steps++;
            nnpc = npc + 32'd4;
            wr = 1'b1;
            dest = ins[20:16];
            val = '0;
            case (op)
                OP_SPECIAL: begin
                    dest = ins[15:11];
                    case (fn)
                        FN_ADDU: val = a + b;
                        FN_SUBU: val = a - b;
                        FN_AND:  val = a & b;
                        FN_OR:   val = a | b;
                        FN_XOR:  val = a ^ b;
                        FN_NOR:  val = ~(a | b);
                        FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
                        FN_SLL:  val = b << ins[10:6];
                        FN_SRL:  val = b >> ins[10:6];
                        FN_SRA:  val = $signed(b) >>> ins[10:6];
                        FN_JR: begin
                            wr = 1'b0;
                            nnpc = a;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: val = a + sImm;
                OP_SLTI:  val = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
                OP_ANDI:  val = a & zImm;
                OP_ORI:   val = a | zImm;
                OP_XORI:  val = a ^ zImm;
                OP_LUI:   val = {ins[15:0], 16'h0};
                OP_LW: begin
                    val = mem[addr[9:2]];
                    acc.we = 1'b0;
                    acc.addr = addr;
                    acc.wdata = '0;
                    memQ.push_back(acc);
                end
                OP_SW: begin
                    mem[addr[9:2]] = b;
                    wr = 1'b0;
                    acc.we = 1'b1;
                    acc.addr = addr;
                    acc.wdata = b;
                    memQ.push_back(acc);
                end
                OP_BEQ, OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) != (op == OP_BNE)) begin
                        nnpc = npc + {sImm[29:0], 2'b00};
                    end
                end
                OP_J, OP_JAL: begin
                    nnpc = {npc[31:28], ins[25:0], 2'b00};
                    wr = (op == OP_JAL);
                    dest = RA_REG;
                    val = pc + 32'd8;
                end
                default: wr = 1'b0; // unknown encodings do nothing
            endcase
            if (wr && dest != '0) begin
                regs[dest] = val;
                entry.pc = pc;
                entry.wen = 1'b1;
                entry.wnum = dest;
                entry.wdata = val;
                expQ.push_back(entry);
            end
            pc = npc;
            npc = nnpc;
        end
    end
    return steps;
endfunction

`endif

//--- tbMipsCore.sv
`timescale 1ns/10ps
`default_nettype none

module tbMipsCore;
    import mipsPkg::*;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } memAccess_t;

    logic     clk = 1'b0;
    logic     reset_i;
    word_t    instrAddr_o;
    logic     instrEn_o;
    word_t    instr_i;
    logic     memEn_o;
    logic     memWe_o;
    word_t    memAddr_o;
    word_t    memWdata_o;
    word_t    memRdata_i;
    wbTrace_t trace_o;

    word_t    imem [256];
    word_t    dmem [256];
    int       progLen;
    logic [31:0] lcgState;
    wbTrace_t expQ [$];
    wbTrace_t expEntry;
    int       nextIdx;
    memAccess_t memQ [$];
    memAccess_t expAccess;
    int       memIdx;
    int       errorCount = 0;
    int       checkCount = 0;
    int       cycleCount = 0;
    int       cycleLimit = 0;

    // initial data memory word as a hash of its index
    function automatic word_t fillWord(int idx);
        return (word_t'(idx) * 32'h9e37_79b9) ^ 32'h0bad_f00d;
    endfunction

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    `include "tbIsaModel.svh"

    mipsCore dut_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .instrAddr_o (instrAddr_o),
        .instrEn_o   (instrEn_o),
        .instr_i     (instr_i),
        .memEn_o     (memEn_o),
        .memWe_o     (memWe_o),
        .memAddr_o   (memAddr_o),
        .memWdata_o  (memWdata_o),
        .memRdata_i  (memRdata_i),
        .trace_o     (trace_o)
    );

    always #5 clk = ~clk;

    assign instr_i    = instrEn_o ? imem[instrAddr_o[9:2]] : '0;
    assign memRdata_i = dmem[memAddr_o[9:2]];

    always @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (memEn_o && memWe_o) begin
            dmem[memAddr_o[9:2]] <= memWdata_o; // word store
        end
    end

    // trace comparison against the model
    always @(negedge clk) begin
        if (reset_i) begin
            nextIdx = 0;
        end else if (trace_o.wen) begin
            checkCount++;
            assert (trace_o.wnum != '0) else begin
                errorCount++;
                $display("A write to register 0 appeared on the trace at pc %h", trace_o.pc);
            end
            assert (nextIdx < expQ.size()) else begin
                errorCount++;
                $display("Unexpected register write on the trace at pc %h", trace_o.pc);
            end
            if (nextIdx < expQ.size()) begin
                expEntry = expQ[nextIdx];
                nextIdx++;
                assert (trace_o.pc == expEntry.pc) else begin
                    errorCount++;
                    $display("Error: trace_o.pc is %h, expected %h", trace_o.pc, expEntry.pc);
                end
                assert (trace_o.wnum == expEntry.wnum) else begin
                    errorCount++;
                    $display("Error: trace_o.wnum is %h, expected %h (pc %h)",
                             trace_o.wnum, expEntry.wnum, expEntry.pc);
                end
                assert (trace_o.wdata == expEntry.wdata) else begin
                    errorCount++;
                    $display("Error: trace_o.wdata is %h, expected %h (pc %h)",
                             trace_o.wdata, expEntry.wdata, expEntry.pc);
                end
            end
        end
    end

    // data port accesses in program order
    always @(negedge clk) begin
        if (reset_i) begin
            memIdx = 0;
            assert (!instrEn_o) else begin
                errorCount++;
                $display("Error: instrEn_o is %h during reset, expected 0", instrEn_o);
            end
        end else if (memEn_o) begin
            assert (memIdx < memQ.size()) else begin
                errorCount++;
                $display("Unexpected data memory access at address %h", memAddr_o);
            end
            if (memIdx < memQ.size()) begin
                expAccess = memQ[memIdx];
                memIdx++;
                assert (memWe_o == expAccess.we) else begin
                    errorCount++;
                    $display("Error: memWe_o is %h, expected %h (address %h)",
                             memWe_o, expAccess.we, expAccess.addr);
                end
                assert (memAddr_o == expAccess.addr) else begin
                    errorCount++;
                    $display("Error: memAddr_o is %h, expected %h",
                             memAddr_o, expAccess.addr);
                end
                assert (!expAccess.we || memWdata_o == expAccess.wdata) else begin
                    errorCount++;
                    $display("Error: memWdata_o is %h, expected %h (address %h)",
                             memWdata_o, expAccess.wdata, expAccess.addr);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!reset_i) begin
            cycleCount <= cycleCount + 1;
        end
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, expected writes did not all retire", cycleCount);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic buildAluChain();
        clearProgram();
        emitInstr(encI(OP_LUI, 1, 0, 'h1234));
        emitInstr(encI(OP_ORI, 1, 1, 'h5678));   // forwarded from memory
        emitInstr(encI(OP_ADDIU, 2, 1, -8));
        emitInstr(encR(FN_SUBU, 3, 2, 1, 0));     // both operands forwarded
        emitInstr(encR(FN_SLL, 4, 0, 3, 4));
        emitInstr(encR(FN_SRA, 5, 0, 4, 2));
        emitInstr(encR(FN_SRL, 6, 0, 4, 28));
        emitInstr(encR(FN_SLT, 7, 3, 1, 0));
        emitInstr(encR(FN_SLTU, 8, 3, 1, 0));
        emitInstr(encR(FN_AND, 9, 1, 3, 0));
        emitInstr(encR(FN_OR, 10, 9, 5, 0));
        emitInstr(encR(FN_XOR, 11, 10, 1, 0));
        emitInstr(encR(FN_NOR, 12, 11, 6, 0));
        emitInstr(encI(OP_XORI, 13, 12, 'hffff));
        emitInstr(encI(OP_ANDI, 14, 13, 'hff00));
        emitInstr(encI(OP_SLTI, 15, 3, -7));
        emitInstr(encR(FN_ADDU, 0, 1, 1, 0));     // dropped since it targets $0
        emitInstr(encR(FN_ADDU, 16, 0, 15, 0));
        endProgram();
    endtask

    task automatic buildLoadStore();
        clearProgram();
        emitInstr(encI(OP_ORI, 1, 0, 'h40));
        emitInstr(encI(OP_LUI, 2, 0, 'hdead));
        emitInstr(encI(OP_ORI, 2, 2, 'hbeef));
        emitInstr(encI(OP_SW, 2, 1, 4));
        emitInstr(encI(OP_LW, 3, 1, 4));
        emitInstr(encR(FN_ADDU, 4, 3, 3, 0));     // load-use bubble
        emitInstr(encI(OP_LW, 5, 1, 8));          // fill word
        emitInstr(encR(FN_SUBU, 6, 5, 3, 0));
        emitInstr(encI(OP_SW, 6, 0, 0));
        emitInstr(encI(OP_LW, 7, 0, 0));
        emitInstr(encI(OP_SW, 7, 1, 12));         // store data right after load
        emitInstr(encI(OP_LW, 8, 1, 12));
        emitInstr(encR(FN_OR, 9, 8, 7, 0));
        emitInstr(encI(OP_LW, 10, 1, 0));
        emitInstr(encI(OP_SW, 10, 1, 16));
        emitInstr(encI(OP_LW, 11, 1, 16));
        endProgram();
    endtask

    task automatic buildBranches();
        clearProgram();
        emitInstr(encI(OP_ORI, 1, 0, 5));
        emitInstr(encI(OP_ORI, 2, 0, 5));
        emitInstr(encI(OP_ORI, 3, 0, 7));
        emitInstr(encI(OP_BEQ, 2, 1, 2));         // taken
        emitInstr(encI(OP_ADDIU, 4, 0, 1));       // delay slot
        emitInstr(encI(OP_ADDIU, 5, 0, 2));       // skipped
        emitInstr(encI(OP_ADDIU, 6, 0, 3));
        emitInstr(encI(OP_BNE, 3, 1, 2));         // taken
        emitInstr(encI(OP_ADDIU, 7, 0, 4));
        emitInstr(encI(OP_ADDIU, 8, 0, 5));       // skipped
        emitInstr(encI(OP_ADDIU, 9, 0, 6));
        emitInstr(encI(OP_BEQ, 3, 1, 2));         // not taken
        emitInstr(encI(OP_ADDIU, 10, 0, 7));
        emitInstr(encI(OP_ADDIU, 11, 0, 8));
        emitInstr(encI(OP_ADDIU, 12, 0, 9));
        emitInstr(encI(OP_BNE, 2, 1, 1));         // not taken
        emitInstr(encI(OP_ADDIU, 13, 0, 10));
        emitInstr(encI(OP_ADDIU, 14, 0, 11));
        emitInstr(encI(OP_ORI, 15, 0, 3));
        emitInstr(encI(OP_ADDIU, 15, 15, -1));    // loop head
        emitInstr(encI(OP_BNE, 0, 15, -2));
        emitInstr(encI(OP_ADDIU, 16, 16, 1));     // runs once per pass
        emitInstr(encI(OP_ADDIU, 17, 16, 0));
        endProgram();
    endtask

    task automatic buildJumps();
        clearProgram();
        emitInstr(encI(OP_ORI, 1, 0, 1));
        emitInstr(encJ(OP_JAL, 6));
        emitInstr(encI(OP_ADDIU, 2, 0, 2));
        emitInstr(encI(OP_ADDIU, 3, 0, 3));       // return point
        emitInstr(encJ(OP_J, 10));
        emitInstr(encI(OP_ADDIU, 4, 0, 4));
        emitInstr(encI(OP_ADDIU, 5, 31, 0));
        emitInstr(encR(FN_JR, 0, 5, 0, 0));       // rs from memory stage
        emitInstr(encI(OP_ADDIU, 6, 0, 6));
        emitInstr(encI(OP_ADDIU, 7, 0, 7));       // never reached
        emitInstr(encI(OP_ADDIU, 8, 31, 1));
        endProgram();
    endtask

    function automatic logic [5:0] randFunct(logic [3:0] k);
        case (k)
            4'd1:    return FN_SUBU;
            4'd2:    return FN_AND;
            4'd3:    return FN_OR;
            4'd4:    return FN_XOR;
            4'd5:    return FN_NOR;
            4'd6:    return FN_SLT;
            4'd7:    return FN_SLTU;
            4'd8:    return FN_SLL;
            4'd9:    return FN_SRL;
            4'd10:   return FN_SRA;
            default: return FN_ADDU;
        endcase
    endfunction

    // registers 0..7 only so dependencies and $0 targets are frequent
    task automatic buildRandom();
        logic [31:0] r;
        int d;
        int s;
        int t;
        int off;
        clearProgram();
        for (int i = 0; i < 40; i++) begin
            r = lcgNext();
            d = int'(r[2:0]);
            s = int'(r[5:3]);
            t = int'(r[8:6]);
            off = int'({r[20:15], 2'b00});
            case (r[31:29])
                3'd0, 3'd1: emitInstr(encR(randFunct(r[12:9]), d, s, t, int'(r[17:13])));
                3'd2: emitInstr(encI(OP_ADDIU, d, s, int'(r[28:13])));
                3'd3: emitInstr(encI(r[9] ? OP_ORI : OP_XORI, d, s, int'(r[28:13])));
                3'd4: emitInstr(encI(r[9] ? OP_ANDI : OP_SLTI, d, s, int'(r[28:13])));
                3'd5: emitInstr(encI(OP_LUI, d, 0, int'(r[28:13])));
                3'd6: emitInstr(encI(OP_LW, d, 0, off));
                default: emitInstr(encI(OP_SW, t, 0, off));
            endcase
        end
        endProgram();
    endtask

    task automatic runTest(input int id, input string name);
        int steps;
        int errsBefore;
        @(posedge clk);
        reset_i <= 1'b1;
        @(posedge clk);
        case (id)
            1: buildAluChain();
            2: buildLoadStore();
            3: buildBranches();
            4: buildJumps();
            default: buildRandom();
        endcase
        steps = runModel();
        cycleLimit = cycleLimit + 3 * steps + 50;
        errsBefore = errorCount;
        repeat (9) @(posedge clk);
        reset_i <= 1'b0;
        while (nextIdx < expQ.size()) begin
            @(posedge clk);
        end
        $display("test %0d %s: %0d instructions, %0d writes checked, %0d errors",
                 id, name, steps, expQ.size(), errorCount - errsBefore);
    endtask

    initial begin
        reset_i = 1'b1;
        lcgState = 32'h4d31_68ce;
        runTest(1, "alu chain");
        runTest(2, "load store");
        runTest(3, "branches");
        runTest(4, "jumps");
        runTest(5, "random");
        $display("5 tests, %0d trace checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
